/* Bender.yml */
package:
  name: wadj

sources:
  # shared package first
  - common/wadj_pkg.sv

  # design
  - rtl/wadj_fifo.sv
  - rtl/pack/wadj_lane_cnt.sv
  - rtl/pack/wadj_lane_pack.sv
  - rtl/wadj_seg_fsm.sv
  - rtl/wadj_top.sv

  # testbench
  - target: test
    files:
      - dv/wadj_tb.sv

/* common/wadj_pkg.sv */
//------------------------------
// width adapter package
// segment geometry, FIFO depths and watermarks
// beat structs, segment info and egress state
//------------------------------
package wadj_pkg;

   //------------------------------
   // segment geometry
   //------------------------------
   localparam int SEG_BYTES = 8;
   localparam int SEG_W     = SEG_BYTES * 8;
   // one narrow segment per ingress beat, four per egress beat
   localparam int ENUM_SEG  = 4;
   localparam int LANE_W    = $clog2(ENUM_SEG);

   //------------------------------
   // FIFO sizing
   //------------------------------
   localparam int IFIFO_DEPTH = 32;
   localparam int EFIFO_DEPTH = 16;
   // holds the larger depth inclusive
   localparam int CNT_W       = 6;

   // trdy_o drops at this ingress occupancy
   localparam int IFIFO_WM = IFIFO_DEPTH - 4;
   // margin for wide beats still inside the packer
   localparam int EFIFO_WM = EFIFO_DEPTH - 4;

   typedef logic [SEG_W-1:0]     seg_data_t;
   typedef logic [SEG_BYTES-1:0] seg_keep_t;
   typedef logic [LANE_W-1:0]    lane_t;
   typedef logic [CNT_W-1:0]     fifo_cnt_t;

   // one narrow beat, 73 bits
   typedef struct packed {
      seg_data_t data;
      seg_keep_t keep;
      logic      last;
   } igr_beat_s;

   // one wide beat, lane 0 in the low segment
   typedef struct packed {
      seg_data_t [ENUM_SEG-1:0] data;
      seg_keep_t [ENUM_SEG-1:0] keep;
      logic      [ENUM_SEG-1:0] last_seg;
      logic                     last;
   } egr_beat_s;

   typedef struct packed {
      logic sop;
      logic eop;
      logic hdr_segment;
      logic payld_segment;
   } seg_info_s;

   // egress packet position
   typedef enum logic [1:0] {
      SEG_FIRST,
      SEG_HDR,
      SEG_PAYLD
   } seg_state_e;

endpackage

/* dv/wadj_tb.sv */
//------------------------------
// testbench for the width adapter
// clock, reset, packet stimulus, reference model
// checking assertions on the egress stream
//------------------------------
module wadj_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import wadj_pkg::*;

   localparam int          MAX_LEN       = 11;
   localparam int          EXP_DEPTH     = 1024;
   localparam int          BEAT_TIMEOUT  = 2000;
   localparam int          BP_TIMEOUT    = 4000;
   localparam int          DRAIN_TIMEOUT = 4000;
   localparam logic [31:0] SEED          = 32'd4501;
   localparam fifo_cnt_t   PAUSE_THR     = 4;

   typedef enum {SINK_RANDOM, SINK_HOLD, SINK_OPEN} sink_mode_e;

   // expected wide beat, lanes in use and segment info
   typedef struct packed {
      egr_beat_s           beat;
      logic [ENUM_SEG-1:0] used;
      seg_info_s           info;
   } exp_beat_s;

   logic      clk;
   logic      rst;
   logic      tvld_i;
   igr_beat_s ibeat;
   logic      trdy_o;
   logic      trdy_i;
   logic      tvld_o;
   egr_beat_s obeat;
   seg_info_s seg_info;
   logic      pause_en_i;
   fifo_cnt_t pause_thr_i;
   logic      rx_pause_o;

   //------------------------------
   // reference model state
   //------------------------------
   exp_beat_s   exp_mem [EXP_DEPTH];
   int          wr_idx = 0;
   int          rd_idx = 0;
   exp_beat_s   exp_head;
   logic        exp_avail;
   igr_beat_s   pkt_buf [MAX_LEN];

   logic [31:0] data_rng;
   logic [31:0] stall_rng;
   sink_mode_e  sink_mode;
   logic        bp_seen;
   logic        seen_ingress  = 1'b0;
   logic        trdy_was_high = 1'b0;
   int          cyc = 0;

   assign exp_head  = exp_mem[rd_idx];
   assign exp_avail = (rd_idx != wr_idx);

   wadj_top i_dut (
      .clk        (clk),
      .rst        (rst),
      .tvld_i     (tvld_i),
      .ibeat_i    (ibeat),
      .trdy_o     (trdy_o),
      .trdy_i     (trdy_i),
      .tvld_o     (tvld_o),
      .obeat_o    (obeat),
      .seg_info_o (seg_info),
      .pause_en_i (pause_en_i),
      .pause_thr_i(pause_thr_i),
      .rx_pause_o (rx_pause_o)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_data_rand();
      data_rng = xorshift32(data_rng);
      return data_rng;
   endfunction

   // used lanes must match, unused lanes carry no keep and no last_seg
   function automatic logic beat_matches(input egr_beat_s got, input exp_beat_s exp);
      logic ok;
      ok = (got.last === exp.beat.last);
      for (int k = 0; k < ENUM_SEG; k++) begin
         if (exp.used[k]) begin
            if (got.data[k] !== exp.beat.data[k] || got.keep[k] !== exp.beat.keep[k] ||
                got.last_seg[k] !== exp.beat.last_seg[k]) begin
               ok = 1'b0;
            end
         end else if (got.keep[k] !== '0 || got.last_seg[k] !== 1'b0) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   //------------------------------
   // reference model
   //------------------------------
   // four narrow beats per wide beat, packet starts in lane 0
   task automatic add_expected(input int len);
      exp_beat_s e;
      int        nw;
      int        idx;
      nw = (len + ENUM_SEG - 1) / ENUM_SEG;
      for (int j = 0; j < nw; j++) begin
         e = '0;
         for (int k = 0; k < ENUM_SEG; k++) begin
            idx = ENUM_SEG * j + k;
            if (idx < len) begin
               e.beat.data[k]     = pkt_buf[idx].data;
               e.beat.keep[k]     = pkt_buf[idx].keep;
               e.beat.last_seg[k] = (idx == len - 1);
               e.used[k]          = 1'b1;
            end
         end
         e.beat.last          = (j == nw - 1);
         e.info.sop           = (j == 0);
         e.info.eop           = (j == nw - 1);
         e.info.hdr_segment   = (j < 2);
         e.info.payld_segment = (j >= 2);
         exp_mem[wr_idx] = e;
         wr_idx++;
      end
   endtask

   //------------------------------
   // stimulus
   //------------------------------
   task automatic send_beat(input igr_beat_s beat);
      int waited;
      waited = 0;
      tvld_i = 1'b1;
      ibeat  = beat;
      while (!trdy_o) begin
         if (waited >= BEAT_TIMEOUT) begin
            stop_run("timeout waiting for trdy_o on an ingress beat");
         end else begin
            @(posedge clk);
            #1;
            waited++;
         end
      end
      // ready seen in this cycle, transfer at the next edge
      @(posedge clk);
      #1;
      tvld_i = 1'b0;
   endtask

   task automatic send_packet();
      int len;
      len = 1 + int'(next_data_rand() % MAX_LEN);
      for (int i = 0; i < len; i++) begin
         pkt_buf[i].data = {next_data_rand(), next_data_rand()};
         pkt_buf[i].keep = '1;
         pkt_buf[i].last = (i == len - 1);
      end
      // short final beat keeps a run of low bytes
      pkt_buf[len-1].keep = seg_keep_t'(8'hff >> (next_data_rand() % SEG_BYTES));
      add_expected(len);
      for (int i = 0; i < len; i++) begin
         send_beat(pkt_buf[i]);
      end
   endtask

   task automatic hold_sink_until_full();
      int waited;
      waited = 0;
      sink_mode = SINK_HOLD;
      while (trdy_o) begin
         if (waited >= BP_TIMEOUT) begin
            stop_run("trdy_o never fell while the egress sink was stalled");
         end else begin
            @(posedge clk);
            #1;
            waited++;
         end
      end
      bp_seen = 1'b1;
      // keep the stall so the hold checks see a full egress FIFO
      repeat (20) @(posedge clk);
      #1;
      sink_mode = SINK_RANDOM;
   endtask

   task automatic drain_egress();
      int waited;
      waited = 0;
      sink_mode = SINK_OPEN;
      while (rd_idx != wr_idx) begin
         if (waited >= DRAIN_TIMEOUT) begin
            stop_run("expected wide beats still missing after the drain timeout");
         end else begin
            @(posedge clk);
            #1;
            waited++;
         end
      end
   endtask

   // egress sink ready pattern
   always @(posedge clk) begin
      #1;
      case (sink_mode)
         SINK_RANDOM: begin
            stall_rng = xorshift32(stall_rng);
            trdy_i    = stall_rng[3] | stall_rng[9];
         end
         SINK_HOLD: trdy_i = 1'b0;
         default:   trdy_i = 1'b1;
      endcase
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (!rst) begin
         if (tvld_i && trdy_o) begin
            seen_ingress <= 1'b1;
         end
         if (trdy_o) begin
            trdy_was_high <= 1'b1;
         end
         if (tvld_o && trdy_i) begin
            rd_idx <= rd_idx + 1;
         end
      end
   end

   //------------------------------
   // checks
   //------------------------------
   a_reset_low : assert property (@(posedge clk)
      (rst && cyc > 0) |-> (!trdy_o && !tvld_o)
   ) else stop_run($sformatf("error %0t: trdy_o or tvld_o high during reset", $time));

   a_no_early_egress : assert property (@(posedge clk) disable iff (rst)
      tvld_o |-> seen_ingress
   ) else stop_run($sformatf("error %0t: egress valid before any ingress beat", $time));

   a_exp_avail : assert property (@(posedge clk) disable iff (rst)
      (tvld_o && trdy_i) |-> exp_avail
   ) else stop_run($sformatf("error %0t: egress transfer with no expected beat", $time));

   a_beat_match : assert property (@(posedge clk) disable iff (rst)
      (tvld_o && trdy_i) |-> beat_matches(obeat, exp_head)
   ) else stop_run($sformatf("error %0t: wide beat %0d differs from model", $time,
                             $sampled(rd_idx)));

   a_info_match : assert property (@(posedge clk) disable iff (rst)
      (tvld_o && trdy_i) |-> (seg_info == exp_head.info)
   ) else stop_run($sformatf("error %0t: segment info %b, expected %b", $time,
                             $sampled(seg_info), $sampled(exp_head.info)));

   a_hold_stable : assert property (@(posedge clk) disable iff (rst)
      (tvld_o && !trdy_i) |=> (tvld_o && $stable(obeat))
   ) else stop_run($sformatf("error %0t: egress beat changed while stalled", $time));

   a_pause_off : assert property (@(posedge clk) disable iff (rst)
      !pause_en_i |-> !rx_pause_o
   ) else stop_run($sformatf("error %0t: rx_pause_o high with pause disabled", $time));

   a_pause_on : assert property (@(posedge clk) disable iff (rst)
      (pause_en_i && pause_thr_i == PAUSE_THR && !trdy_o && trdy_was_high) |-> rx_pause_o
   ) else stop_run($sformatf("error %0t: rx_pause_o low while ingress is full", $time));

   initial begin
      rst         = 1'b1;
      tvld_i      = 1'b0;
      ibeat       = '0;
      trdy_i      = 1'b0;
      pause_en_i  = 1'b0;
      pause_thr_i = PAUSE_THR;
      data_rng    = SEED;
      stall_rng   = ~SEED;
      sink_mode   = SINK_RANDOM;
      bp_seen     = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      // idle gap, egress must stay quiet
      repeat (6) @(posedge clk);
      #1;
      repeat (20) send_packet();
      // long stall with pause enabled
      pause_en_i = 1'b1;
      fork
         begin
            while (!bp_seen) begin
               send_packet();
            end
         end
         begin
            hold_sink_until_full();
         end
      join
      repeat (8) send_packet();
      pause_en_i = 1'b0;
      repeat (10) send_packet();
      drain_egress();
      repeat (10) @(posedge clk);
      #1;
      if (rd_idx == wr_idx && !tvld_o) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         stop_run("extra wide beat on the egress after the last packet");
      end
   end

endmodule

/* project.f */
common/wadj_pkg.sv
rtl/wadj_fifo.sv
rtl/pack/wadj_lane_cnt.sv
rtl/pack/wadj_lane_pack.sv
rtl/wadj_seg_fsm.sv
rtl/wadj_top.sv
dv/wadj_tb.sv

/* rtl/pack/wadj_lane_cnt.sv */
//------------------------------
// lane counter for the packer
// target lane per pop, flush strobe
//------------------------------
module wadj_lane_cnt (
   input  logic            clk,
   input  logic            rst,
   input  logic            pop_i,
   input  logic            last_i,
   output wadj_pkg::lane_t lane_o,
   output logic            flush_o
);
   import wadj_pkg::*;

   logic top_lane;

   // wide beat closes on the top lane or on end of packet
   always_comb begin
      top_lane = (lane_o == lane_t'(ENUM_SEG - 1));
      flush_o  = pop_i && (last_i || top_lane);
   end

   // a new packet always starts in lane 0
   always_ff @(posedge clk) begin
      if (rst) begin
         lane_o <= '0;
      end else if (pop_i) begin
         if (last_i || top_lane) begin
            lane_o <= '0;
         end else begin
            lane_o <= lane_o + 1'b1;
         end
      end
   end

   // lane choice needs a known end of packet
   a_last_known : assert property (
      @(posedge clk) disable iff (rst)
      pop_i |-> !$isunknown(last_i)
   ) else $error("wadj_lane_cnt unknown last bit on pop");

endmodule

/* rtl/pack/wadj_lane_pack.sv */
//------------------------------
// lane register array
// narrow beats into one wide beat, registered push
//------------------------------
module wadj_lane_pack (
   input  logic                clk,
   input  logic                rst,
   input  logic                pop_i,
   input  wadj_pkg::lane_t     lane_i,
   input  logic                flush_i,
   input  wadj_pkg::igr_beat_s beat_i,
   output wadj_pkg::egr_beat_s beat_o,
   output logic                push_o
);
   import wadj_pkg::*;

   egr_beat_s beat_q;

   //------------------------------
   // lane write
   //------------------------------
   // popped beat into its lane
   always_ff @(posedge clk) begin
      if (pop_i) begin
         for (int k = 0; k < ENUM_SEG; k++) begin
            if (lane_t'(k) == lane_i) begin
               beat_q.data[k]     <= beat_i.data;
               beat_q.keep[k]     <= beat_i.keep;
               beat_q.last_seg[k] <= beat_i.last;
            end else if (lane_t'(k) > lane_i) begin
               // no stale bytes above a short final beat
               beat_q.keep[k]     <= '0;
               beat_q.last_seg[k] <= 1'b0;
            end
         end
         if (flush_i) begin
            beat_q.last <= beat_i.last;
         end
      end
   end

   //------------------------------
   // push strobe
   //------------------------------
   // one cycle behind the flushing pop
   always_ff @(posedge clk) begin
      if (rst) begin
         push_o <= 1'b0;
      end else begin
         push_o <= flush_i;
      end
   end

   assign beat_o = beat_q;

   // a second wide beat needs another pop in between
   a_push_needs_pop : assert property (
      @(posedge clk) disable iff (rst)
      (push_o && !pop_i) |=> !push_o
   ) else $error("wadj_lane_pack push without pop");

endmodule

/* rtl/wadj_fifo.sv */
//------------------------------
// synchronous show-ahead FIFO
// head presented combinationally, occupancy count
//------------------------------
module wadj_fifo #(
   parameter int  DEPTH = 16,
   parameter type T     = logic
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                push_i,
   input  logic                pop_i,
   input  T                    din_i,
   output T                    dout_o,
   output logic                empty_o,
   output wadj_pkg::fifo_cnt_t count_o
);
   import wadj_pkg::*;

   T                         mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;

   //------------------------------
   // storage
   //------------------------------
   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   //------------------------------
   // pointers and occupancy
   //------------------------------
   // power-of-two depth, so the pointers wrap by themselves
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_o <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count_o <= count_o + 1'b1;
            2'b01:   count_o <= count_o - 1'b1;
            default: count_o <= count_o;
         endcase
      end
   end

   // head of queue
   always_comb begin
      dout_o  = mem[rd_ptr];
      empty_o = (count_o == '0);
   end

   // caller must not write a full FIFO unless it reads in the same cycle
   a_no_overflow : assert property (
      @(posedge clk) disable iff (rst)
      (push_i && (count_o == fifo_cnt_t'(DEPTH))) |-> pop_i
   ) else $error("wadj_fifo push while full");

   // caller must not read an empty FIFO
   a_no_underflow : assert property (
      @(posedge clk) disable iff (rst)
      !(pop_i && empty_o)
   ) else $error("wadj_fifo pop while empty");

endmodule

/* rtl/wadj_seg_fsm.sv */
//------------------------------
// egress packet state machine
// sop, eop, header and payload flags
//------------------------------
module wadj_seg_fsm (
   input  logic                clk,
   input  logic                rst,
   input  logic                pop_i,
   input  logic                last_i,
   input  logic                valid_i,
   output wadj_pkg::seg_info_s info_o
);
   import wadj_pkg::*;

   seg_state_e state_q;
   seg_state_e state_d;

   //------------------------------
   // next state
   //------------------------------
   always_comb begin
      state_d = state_q;
      if (pop_i) begin
         if (last_i) begin
            state_d = SEG_FIRST;
         end else begin
            case (state_q)
               SEG_FIRST: state_d = SEG_HDR;
               SEG_HDR:   state_d = SEG_PAYLD;
               default:   state_d = SEG_PAYLD;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= SEG_FIRST;
      end else begin
         state_q <= state_d;
      end
   end

   //------------------------------
   // segment info
   //------------------------------
   // first two wide beats carry the header
   always_comb begin
      info_o.sop           = valid_i && (state_q == SEG_FIRST);
      info_o.eop           = last_i;
      info_o.hdr_segment   = (state_q == SEG_FIRST) || (state_q == SEG_HDR);
      info_o.payld_segment = (state_q == SEG_PAYLD);
   end

   // state only advances on a valid head
   a_pop_valid : assert property (
      @(posedge clk) disable iff (rst)
      pop_i |-> valid_i
   ) else $error("wadj_seg_fsm pop without a valid head");

endmodule

/* rtl/wadj_top.sv */
//------------------------------
// ingress width adapter, 1 to 4 segments
// FIFO watermark flow control, pause level
// ingress FIFO, packer, egress FIFO, segment info
//------------------------------
module wadj_top (
   input  logic                clk,
   input  logic                rst,
   // narrow ingress stream
   input  logic                tvld_i,
   input  wadj_pkg::igr_beat_s ibeat_i,
   output logic                trdy_o,
   // wide egress stream
   input  logic                trdy_i,
   output logic                tvld_o,
   output wadj_pkg::egr_beat_s obeat_o,
   output wadj_pkg::seg_info_s seg_info_o,
   // pause
   input  logic                pause_en_i,
   input  wadj_pkg::fifo_cnt_t pause_thr_i,
   output logic                rx_pause_o
);
   import wadj_pkg::*;

   igr_beat_s ififo_head;
   logic      ififo_push;
   logic      ififo_pop;
   logic      ififo_empty;
   fifo_cnt_t ififo_cnt;

   lane_t     lane;
   logic      flush;
   egr_beat_s pack_beat;
   logic      pack_push;

   logic      efifo_pop;
   logic      efifo_empty;
   fifo_cnt_t efifo_cnt;

   //------------------------------
   // flow control
   //------------------------------
   // registered ready, low through the first cycle after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         trdy_o <= 1'b0;
      end else begin
         trdy_o <= (ififo_cnt < fifo_cnt_t'(IFIFO_WM));
      end
   end

   // egress watermark throttles the packer
   always_comb begin
      ififo_push = tvld_i && trdy_o;
      ififo_pop  = !ififo_empty && (efifo_cnt < fifo_cnt_t'(EFIFO_WM));
      efifo_pop  = trdy_i && !efifo_empty;
      tvld_o     = !efifo_empty;
   end

   // advisory only, ready is unaffected
   assign rx_pause_o = pause_en_i && (ififo_cnt > pause_thr_i);

   //------------------------------
   // datapath
   //------------------------------
   wadj_fifo #(.DEPTH(IFIFO_DEPTH), .T(igr_beat_s)) u_ififo (
      .clk     (clk),
      .rst     (rst),
      .push_i  (ififo_push),
      .pop_i   (ififo_pop),
      .din_i   (ibeat_i),
      .dout_o  (ififo_head),
      .empty_o (ififo_empty),
      .count_o (ififo_cnt)
   );

   wadj_lane_cnt u_lane_cnt (
      .clk     (clk),
      .rst     (rst),
      .pop_i   (ififo_pop),
      .last_i  (ififo_head.last),
      .lane_o  (lane),
      .flush_o (flush)
   );

   wadj_lane_pack u_lane_pack (
      .clk     (clk),
      .rst     (rst),
      .pop_i   (ififo_pop),
      .lane_i  (lane),
      .flush_i (flush),
      .beat_i  (ififo_head),
      .beat_o  (pack_beat),
      .push_o  (pack_push)
   );

   wadj_fifo #(.DEPTH(EFIFO_DEPTH), .T(egr_beat_s)) u_efifo (
      .clk     (clk),
      .rst     (rst),
      .push_i  (pack_push),
      .pop_i   (efifo_pop),
      .din_i   (pack_beat),
      .dout_o  (obeat_o),
      .empty_o (efifo_empty),
      .count_o (efifo_cnt)
   );

   wadj_seg_fsm u_seg_fsm (
      .clk     (clk),
      .rst     (rst),
      .pop_i   (efifo_pop),
      .last_i  (obeat_o.last),
      .valid_i (tvld_o),
      .info_o  (seg_info_o)
   );

endmodule
